// File: hw/ex_isa_pkg.sv
/* ISA-level types for the execute stage: data width, opcodes and the
   decoded / retire packets exchanged with the neighbouring stages */
package ex_isa_pkg;

  parameter int XLEN = 64;

  // opcodes as produced by the decoder
  typedef enum logic [7:0] {
    NOP = 8'h00,
    ADD, SUB, AND, OR, XOR,
    SLL, SRL, SRA, SLT, SLTU,
    LUI,
    BEQ, BNE, BLT, BGE,
    JAL, JALR,
    CSRRW, CSRRS, CSRRC,
    ECALL, MRET
  } op_e;

  // op1/op2 alu sources, op3 branch offset
  // csr ops carry the address in op2[11:0] and the source in op1
  typedef struct packed {
    op_e              opcode;
    logic [XLEN-1:0]  pc;
    logic [31:0]      inst;
    logic [XLEN-1:0]  op1;
    logic [XLEN-1:0]  op2;
    logic [XLEN-1:0]  op3;
    logic [4:0]       rd;
    logic             rd_wen;
  } dec_pkt_t;

  typedef struct packed {
    logic [XLEN-1:0]  pc;
    logic [31:0]      inst;
    logic [4:0]       rd;
    logic             rd_wen;
    logic [XLEN-1:0]  rd_wdata;
    logic             jmp;
    logic [XLEN-1:0]  jmpaddr;
    logic [31:0]      intr_no;
  } ret_pkt_t;

endpackage

// File: hw/ex_csr_pkg.sv
/* machine-mode CSR definitions: addresses, access request,
   trap causes and the status / enable bit positions */
package ex_csr_pkg;

  parameter logic [11:0] MSTATUS  = 12'h300;
  parameter logic [11:0] MIE      = 12'h304;
  parameter logic [11:0] MTVEC    = 12'h305;
  parameter logic [11:0] MSCRATCH = 12'h340;
  parameter logic [11:0] MEPC     = 12'h341;
  parameter logic [11:0] MCAUSE   = 12'h342;

  // one access per cycle, read is combinational
  typedef struct packed {
    logic [11:0]                  addr;
    logic                         ren;
    logic                         wen;
    logic [ex_isa_pkg::XLEN-1:0]  wdata;
  } csr_req_t;

  parameter logic [ex_isa_pkg::XLEN-1:0] CAUSE_ECALL_M = 64'd11;
  // interrupt flag in the top bit
  parameter logic [ex_isa_pkg::XLEN-1:0] CAUSE_MTIMER  = {1'b1, 63'd7};
  parameter logic [31:0]                 INTR_MTIMER   = 32'd7;

  parameter int MSTATUS_MIE_BIT  = 3;
  parameter int MSTATUS_MPIE_BIT = 7;
  parameter int MIE_MTIE_BIT     = 7;

endpackage

// File: hw/ex_csr_file.sv
`timescale 1ns/1ps
/* machine CSRs used by the execute stage; one access port with
   combinational read, plus the interrupt enable levels */
module ex_csr_file #(
  parameter logic [ex_isa_pkg::XLEN-1:0] MTVEC_RESET = 64'h0000_0000_8000_0100
) (
  input  logic                               clk,
  input  logic                               rst,
  input  ex_csr_pkg::csr_req_t               i_csr,
  output logic [ex_isa_pkg::XLEN-1:0]        o_rdata,
  output logic                               o_mstatus_mie,
  output logic                               o_mie_mtie
);

  localparam int XW = ex_isa_pkg::XLEN;

  logic [XW-1:0] mstatus;
  logic [XW-1:0] mie;
  logic [XW-1:0] mtvec;
  logic [XW-1:0] mscratch;
  logic [XW-1:0] mepc;
  logic [XW-1:0] mcause;

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus  <= '0;
      mie      <= '0;
      mtvec    <= MTVEC_RESET;
      mscratch <= '0;
      mepc     <= '0;
      mcause   <= '0;
    end else if (i_csr.wen) begin
      // unknown addresses fall through
      case (i_csr.addr)
        ex_csr_pkg::MSTATUS:  mstatus  <= i_csr.wdata;
        ex_csr_pkg::MIE:      mie      <= i_csr.wdata;
        ex_csr_pkg::MTVEC:    mtvec    <= i_csr.wdata;
        ex_csr_pkg::MSCRATCH: mscratch <= i_csr.wdata;
        ex_csr_pkg::MEPC:     mepc     <= i_csr.wdata;
        ex_csr_pkg::MCAUSE:   mcause   <= i_csr.wdata;
        default: ;
      endcase
    end
  end

  always_comb begin
    o_rdata = '0;
    if (i_csr.ren) begin
      case (i_csr.addr)
        ex_csr_pkg::MSTATUS:  o_rdata = mstatus;
        ex_csr_pkg::MIE:      o_rdata = mie;
        ex_csr_pkg::MTVEC:    o_rdata = mtvec;
        ex_csr_pkg::MSCRATCH: o_rdata = mscratch;
        ex_csr_pkg::MEPC:     o_rdata = mepc;
        ex_csr_pkg::MCAUSE:   o_rdata = mcause;
        default:              o_rdata = '0;
      endcase
    end
  end

  assign o_mstatus_mie = mstatus[ex_csr_pkg::MSTATUS_MIE_BIT];
  assign o_mie_mtie    = mie[ex_csr_pkg::MIE_MTIE_BIT];

endmodule

// File: hw/ex_alu_unit.sv
`timescale 1ns/1ps
/* single-cycle computation channel: integer ops, branches and jumps,
   and CSR read-modify-write; all outputs are zero while disabled */
module ex_alu_unit (
  input  logic                               i_en,
  input  ex_isa_pkg::dec_pkt_t               i_pkt,
  input  logic [ex_isa_pkg::XLEN-1:0]        i_csr_rdata,
  output ex_csr_pkg::csr_req_t               o_csr,
  output logic                               o_jmp,
  output logic [ex_isa_pkg::XLEN-1:0]        o_jmpaddr,
  output logic [ex_isa_pkg::XLEN-1:0]        o_rd_wdata
);

  localparam int XW = ex_isa_pkg::XLEN;

  logic [XW-1:0] op1;
  logic [XW-1:0] op2;
  logic [5:0]    shamt;
  logic [XW-1:0] br_target;
  logic [XW-1:0] jalr_sum;
  logic [XW-1:0] link_addr;
  logic          signed_lt;
  logic          unsigned_lt;
  logic          br_taken;
  logic          csr_access;

  assign op1         = i_pkt.op1;
  assign op2         = i_pkt.op2;
  assign shamt       = op2[5:0];
  assign br_target   = i_pkt.pc + i_pkt.op3;
  assign jalr_sum    = op1 + i_pkt.op3;
  assign link_addr   = i_pkt.pc + 64'd4;
  assign signed_lt   = $signed(op1) < $signed(op2);
  assign unsigned_lt = op1 < op2;
  assign csr_access  = (i_pkt.opcode == ex_isa_pkg::CSRRW) |
                       (i_pkt.opcode == ex_isa_pkg::CSRRS) |
                       (i_pkt.opcode == ex_isa_pkg::CSRRC);

  always_comb begin
    case (i_pkt.opcode)
      ex_isa_pkg::BEQ: br_taken = (op1 == op2);
      ex_isa_pkg::BNE: br_taken = (op1 != op2);
      ex_isa_pkg::BLT: br_taken = signed_lt;
      ex_isa_pkg::BGE: br_taken = !signed_lt;
      default:         br_taken = 1'b0;
    endcase
  end

  always_comb begin
    o_csr      = '0;
    o_jmp      = 1'b0;
    o_jmpaddr  = '0;
    o_rd_wdata = '0;
    if (i_en) begin
      case (i_pkt.opcode)
        ex_isa_pkg::ADD:  o_rd_wdata = op1 + op2;
        ex_isa_pkg::SUB:  o_rd_wdata = op1 - op2;
        ex_isa_pkg::AND:  o_rd_wdata = op1 & op2;
        ex_isa_pkg::OR:   o_rd_wdata = op1 | op2;
        ex_isa_pkg::XOR:  o_rd_wdata = op1 ^ op2;
        ex_isa_pkg::SLL:  o_rd_wdata = op1 << shamt;
        ex_isa_pkg::SRL:  o_rd_wdata = op1 >> shamt;
        ex_isa_pkg::SRA:  o_rd_wdata = $signed(op1) >>> shamt;
        ex_isa_pkg::SLT:  o_rd_wdata = {{(XW-1){1'b0}}, signed_lt};
        ex_isa_pkg::SLTU: o_rd_wdata = {{(XW-1){1'b0}}, unsigned_lt};
        // upper immediate already shifted by the decoder
        ex_isa_pkg::LUI:  o_rd_wdata = op1;
        ex_isa_pkg::BEQ, ex_isa_pkg::BNE, ex_isa_pkg::BLT, ex_isa_pkg::BGE: begin
          o_jmp     = br_taken;
          o_jmpaddr = br_taken ? br_target : '0;
        end
        ex_isa_pkg::JAL: begin
          o_jmp      = 1'b1;
          o_jmpaddr  = br_target;
          o_rd_wdata = link_addr;
        end
        ex_isa_pkg::JALR: begin
          o_jmp      = 1'b1;
          o_jmpaddr  = {jalr_sum[XW-1:1], 1'b0};
          o_rd_wdata = link_addr;
        end
        ex_isa_pkg::CSRRW: o_csr.wdata = op1;
        ex_isa_pkg::CSRRS: o_csr.wdata = i_csr_rdata | op1;
        ex_isa_pkg::CSRRC: o_csr.wdata = i_csr_rdata & ~op1;
        default: o_rd_wdata = '0;
      endcase
      // old csr value goes back to rd
      if (csr_access) begin
        o_csr.addr = op2[11:0];
        o_csr.ren  = 1'b1;
        o_csr.wen  = 1'b1;
        o_rd_wdata = i_csr_rdata;
      end
    end
  end

endmodule

// File: hw/ex_trap_unit.sv
`timescale 1ns/1ps
/* trap channel: sequences the CSR updates of ecall, timer interrupt entry
   and mret over three states, then holds the pc redirect until released */
module ex_trap_unit (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               i_en,
  input  logic                               i_is_intr,
  input  ex_isa_pkg::dec_pkt_t               i_pkt,
  input  logic [ex_isa_pkg::XLEN-1:0]        i_csr_rdata,
  output ex_csr_pkg::csr_req_t               o_csr,
  output logic                               o_jmp,
  output logic [ex_isa_pkg::XLEN-1:0]        o_jmpaddr,
  output logic                               o_done
);

  localparam int XW = ex_isa_pkg::XLEN;

  typedef enum logic [2:0] {ST_IDLE, ST_S1, ST_S2, ST_S3, ST_DONE} state_e;

  state_e        state;
  state_e        step;
  logic          launch;
  logic          is_entry;
  logic [XW-1:0] cause;
  logic [XW-1:0] mstatus_next;
  logic [XW-1:0] target;

  assign launch   = (state == ST_IDLE) & i_en;
  // first step runs in the cycle the enable arrives
  assign step     = launch ? ST_S1 : state;
  assign is_entry = i_is_intr | (i_pkt.opcode == ex_isa_pkg::ECALL);
  assign cause    = i_is_intr ? ex_csr_pkg::CAUSE_MTIMER : ex_csr_pkg::CAUSE_ECALL_M;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: if (i_en) state <= ST_S2;
        ST_S2:   state <= ST_S3;
        ST_S3:   state <= ST_DONE;
        ST_DONE: if (!i_en) state <= ST_IDLE;
        default: state <= ST_IDLE;
      endcase
    end
  end

  // mret target, mepc read in the first step
  always_ff @(posedge clk) begin
    if (launch && !is_entry) begin
      target <= i_csr_rdata;
    end
  end

  always_comb begin
    mstatus_next = i_csr_rdata;
    if (is_entry) begin
      mstatus_next[ex_csr_pkg::MSTATUS_MPIE_BIT] = i_csr_rdata[ex_csr_pkg::MSTATUS_MIE_BIT];
      mstatus_next[ex_csr_pkg::MSTATUS_MIE_BIT]  = 1'b0;
    end else begin
      mstatus_next[ex_csr_pkg::MSTATUS_MIE_BIT]  = i_csr_rdata[ex_csr_pkg::MSTATUS_MPIE_BIT];
      mstatus_next[ex_csr_pkg::MSTATUS_MPIE_BIT] = 1'b1;
    end
  end

  always_comb begin
    o_csr = '0;
    case (step)
      ST_S1: begin
        o_csr.addr  = ex_csr_pkg::MEPC;
        o_csr.ren   = !is_entry;
        o_csr.wen   = is_entry;
        o_csr.wdata = is_entry ? i_pkt.pc : '0;
      end
      // mret has nothing to do here
      ST_S2: begin
        o_csr.addr  = ex_csr_pkg::MCAUSE;
        o_csr.wen   = is_entry;
        o_csr.wdata = is_entry ? cause : '0;
      end
      ST_S3: begin
        o_csr.addr  = ex_csr_pkg::MSTATUS;
        o_csr.ren   = 1'b1;
        o_csr.wen   = 1'b1;
        o_csr.wdata = mstatus_next;
      end
      // trap entry redirects to mtvec, read while the redirect is held
      ST_DONE: begin
        o_csr.addr = ex_csr_pkg::MTVEC;
        o_csr.ren  = is_entry;
      end
      default: o_csr = '0;
    endcase
  end

  assign o_done    = (state == ST_S3);
  assign o_jmp     = i_en & (state == ST_DONE);
  assign o_jmpaddr = o_jmp ? (is_entry ? i_csr_rdata : target) : '0;

endmodule

// File: hw/ex_stage_ctrl.sv
`timescale 1ns/1ps
/* execute stage control: accepts decoded packets, picks the computation or
   trap channel, and presents the merged result as a retire request */
module ex_stage_ctrl (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               i_dec_req,
  input  ex_isa_pkg::dec_pkt_t               i_dec_pkt,
  input  logic                               i_ret_ack,
  input  logic                               i_mtime_overflow,
  input  logic                               i_mstatus_mie,
  input  logic                               i_mie_mtie,
  input  ex_csr_pkg::csr_req_t               i_alu_csr,
  input  logic                               i_alu_jmp,
  input  logic [ex_isa_pkg::XLEN-1:0]        i_alu_jmpaddr,
  input  logic [ex_isa_pkg::XLEN-1:0]        i_alu_rd_wdata,
  input  ex_csr_pkg::csr_req_t               i_trap_csr,
  input  logic                               i_trap_jmp,
  input  logic [ex_isa_pkg::XLEN-1:0]        i_trap_jmpaddr,
  input  logic                               i_trap_done,
  output logic                               o_dec_ack,
  output ex_isa_pkg::dec_pkt_t               o_pkt,
  output logic                               o_alu_en,
  output logic                               o_trap_en,
  output logic                               o_is_intr,
  output ex_csr_pkg::csr_req_t               o_csr,
  output logic                               o_ret_req,
  output ex_isa_pkg::ret_pkt_t               o_ret_pkt
);

  typedef enum logic [1:0] {ST_IDLE, ST_BUSY, ST_REQ} state_e;

  state_e               state;
  ex_isa_pkg::dec_pkt_t pkt_q;
  logic                 dec_hs;
  logic                 ret_hs;
  logic                 take_intr;
  logic                 to_trap;

  assign o_dec_ack = (state == ST_IDLE);
  assign o_ret_req = (state == ST_REQ);
  assign dec_hs    = i_dec_req & o_dec_ack;
  assign ret_hs    = o_ret_req & i_ret_ack;

  // timer interrupt preempts whatever arrives
  assign take_intr = i_mstatus_mie & i_mie_mtie & i_mtime_overflow;
  assign to_trap   = take_intr | (i_dec_pkt.opcode == ex_isa_pkg::ECALL) |
                     (i_dec_pkt.opcode == ex_isa_pkg::MRET);

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= ST_IDLE;
      o_alu_en  <= 1'b0;
      o_trap_en <= 1'b0;
      o_is_intr <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (dec_hs) begin
            o_is_intr <= take_intr;
            if (to_trap) begin
              o_trap_en <= 1'b1;
              state     <= ST_BUSY;
            end else begin
              // single-cycle unit, result is ready right away
              o_alu_en <= 1'b1;
              state    <= ST_REQ;
            end
          end
        end
        ST_BUSY: begin
          if (i_trap_done) begin
            state <= ST_REQ;
          end
        end
        ST_REQ: begin
          if (i_ret_ack) begin
            state     <= ST_IDLE;
            o_alu_en  <= 1'b0;
            o_trap_en <= 1'b0;
            o_is_intr <= 1'b0;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (dec_hs) begin
      pkt_q <= i_dec_pkt;
    end
  end

  assign o_pkt = pkt_q;

  // alu csr write lands once, when its retire is taken
  always_comb begin
    o_csr = '0;
    if (o_alu_en) begin
      o_csr     = i_alu_csr;
      o_csr.wen = i_alu_csr.wen & ret_hs;
    end else if (o_trap_en) begin
      o_csr = i_trap_csr;
    end
  end

  always_comb begin
    o_ret_pkt = '0;
    if (o_ret_req) begin
      o_ret_pkt.pc       = pkt_q.pc;
      o_ret_pkt.inst     = pkt_q.inst;
      o_ret_pkt.rd       = pkt_q.rd;
      o_ret_pkt.rd_wen   = pkt_q.rd_wen & o_alu_en;
      o_ret_pkt.rd_wdata = i_alu_rd_wdata;
      o_ret_pkt.jmp      = o_alu_en ? i_alu_jmp : i_trap_jmp;
      o_ret_pkt.jmpaddr  = o_alu_en ? i_alu_jmpaddr : i_trap_jmpaddr;
      o_ret_pkt.intr_no  = o_is_intr ? ex_csr_pkg::INTR_MTIMER : 32'd0;
    end
  end

endmodule

// File: hw/ex_subsys_top.sv
`timescale 1ns/1ps
/* execute stage subsystem: control, computation and trap channels
   and the machine CSRs, between the decode and retire handshakes */
module ex_subsys_top #(
  parameter logic [ex_isa_pkg::XLEN-1:0] MTVEC_RESET = 64'h0000_0000_8000_0100
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  i_dec_req,
  input  ex_isa_pkg::dec_pkt_t  i_dec_pkt,
  output logic                  o_dec_ack,
  output logic                  o_ret_req,
  output ex_isa_pkg::ret_pkt_t  o_ret_pkt,
  input  logic                  i_ret_ack,
  input  logic                  i_mtime_overflow
);

  localparam int XW = ex_isa_pkg::XLEN;

  ex_isa_pkg::dec_pkt_t pkt;
  logic                 alu_en;
  logic                 trap_en;
  logic                 is_intr;
  ex_csr_pkg::csr_req_t csr;
  ex_csr_pkg::csr_req_t alu_csr;
  ex_csr_pkg::csr_req_t trap_csr;
  logic [XW-1:0]        csr_rdata;
  logic                 mstatus_mie;
  logic                 mie_mtie;
  logic                 alu_jmp;
  logic [XW-1:0]        alu_jmpaddr;
  logic [XW-1:0]        alu_rd_wdata;
  logic                 trap_jmp;
  logic [XW-1:0]        trap_jmpaddr;
  logic                 trap_done;

  ex_stage_ctrl u_ex_stage_ctrl (
    .clk(clk), .rst(rst), .i_dec_req(i_dec_req), .i_dec_pkt(i_dec_pkt),
    .i_ret_ack(i_ret_ack), .i_mtime_overflow(i_mtime_overflow),
    .i_mstatus_mie(mstatus_mie), .i_mie_mtie(mie_mtie),
    .i_alu_csr(alu_csr), .i_alu_jmp(alu_jmp), .i_alu_jmpaddr(alu_jmpaddr),
    .i_alu_rd_wdata(alu_rd_wdata), .i_trap_csr(trap_csr), .i_trap_jmp(trap_jmp),
    .i_trap_jmpaddr(trap_jmpaddr), .i_trap_done(trap_done),
    .o_dec_ack(o_dec_ack), .o_pkt(pkt), .o_alu_en(alu_en), .o_trap_en(trap_en),
    .o_is_intr(is_intr), .o_csr(csr), .o_ret_req(o_ret_req), .o_ret_pkt(o_ret_pkt)
  );

  ex_alu_unit u_ex_alu_unit (
    .i_en(alu_en), .i_pkt(pkt), .i_csr_rdata(csr_rdata), .o_csr(alu_csr),
    .o_jmp(alu_jmp), .o_jmpaddr(alu_jmpaddr), .o_rd_wdata(alu_rd_wdata)
  );

  ex_trap_unit u_ex_trap_unit (
    .clk(clk), .rst(rst), .i_en(trap_en), .i_is_intr(is_intr), .i_pkt(pkt),
    .i_csr_rdata(csr_rdata), .o_csr(trap_csr), .o_jmp(trap_jmp),
    .o_jmpaddr(trap_jmpaddr), .o_done(trap_done)
  );

  ex_csr_file #(.MTVEC_RESET(MTVEC_RESET)) u_ex_csr_file (
    .clk(clk), .rst(rst), .i_csr(csr), .o_rdata(csr_rdata),
    .o_mstatus_mie(mstatus_mie), .o_mie_mtie(mie_mtie)
  );

endmodule

// File: tb/ex_stage_ctrl_assert.sv
`timescale 1ns/1ps
/* handshake checks for the execute stage control, bound into ex_stage_ctrl */
module ex_stage_ctrl_assert (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  i_dec_ack,
  input  logic                  i_ret_req,
  input  logic                  i_ret_ack,
  input  logic                  i_alu_en,
  input  logic                  i_trap_en,
  input  ex_isa_pkg::ret_pkt_t  i_ret_pkt
);

  int fail_count = 0;

  // retire request and its packet hold until taken
  ret_hold: assert property (@(posedge clk) disable iff (rst)
    i_ret_req && !i_ret_ack |=> i_ret_req && $stable(i_ret_pkt))
    else begin
      fail_count++;
      $error("retire request dropped or packet changed before ack");
    end

  one_channel: assert property (@(posedge clk) disable iff (rst) !(i_alu_en && i_trap_en))
    else begin
      fail_count++;
      $error("both channel enables high");
    end

  no_ack_busy: assert property (@(posedge clk) disable iff (rst)
    (i_alu_en || i_trap_en) |-> !i_dec_ack)
    else begin
      fail_count++;
      $error("decode ack high while a packet is in flight");
    end

endmodule

// File: tb/ex_tb.sv
`timescale 1ns/1ps
/* directed testbench for the execute stage subsystem: ALU, branches,
   CSR ops, ecall, timer interrupt and mret through the req/ack ports */
module ex_tb;

  localparam logic [63:0] MTVEC_RST      = 64'h0000_0000_8000_0100;
  localparam int          NUM_PKTS       = 46;
  localparam int          TIMEOUT_CYCLES = 40 * NUM_PKTS + 10;

  logic                 clk;
  logic                 rst;
  logic                 i_dec_req;
  ex_isa_pkg::dec_pkt_t i_dec_pkt;
  logic                 o_dec_ack;
  logic                 o_ret_req;
  ex_isa_pkg::ret_pkt_t o_ret_pkt;
  logic                 i_ret_ack;
  logic                 i_mtime_overflow;

  logic [15:0] lfsr = 16'd26873;
  logic [63:0] pc_next = 64'h0000_0000_8000_0000;
  logic [63:0] irq_pc;
  int          issued = 0;
  int          cycle_cnt = 0;

  ex_subsys_top #(.MTVEC_RESET(MTVEC_RST)) u_ex_subsys_top (
    .clk(clk), .rst(rst), .i_dec_req(i_dec_req), .i_dec_pkt(i_dec_pkt),
    .o_dec_ack(o_dec_ack), .o_ret_req(o_ret_req), .o_ret_pkt(o_ret_pkt),
    .i_ret_ack(i_ret_ack), .i_mtime_overflow(i_mtime_overflow)
  );

  bind ex_stage_ctrl ex_stage_ctrl_assert u_ctrl_assert (
    .clk(clk), .rst(rst), .i_dec_ack(o_dec_ack), .i_ret_req(o_ret_req),
    .i_ret_ack(i_ret_ack), .i_alu_en(o_alu_en), .i_trap_en(o_trap_en),
    .i_ret_pkt(o_ret_pkt)
  );

  always #10 clk = ~clk;

  task automatic stop_run();
    $display("Regression failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic value_error(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
    $display("ERR %0t: %s got 0x%h expected 0x%h", $time, what, got, exp);
    stop_run();
  endtask

  task automatic plain_error(input string what);
    $display("%0t: %s", $time, what);
    stop_run();
  endtask

  always @(negedge clk) begin
    cycle_cnt++;
    if (u_ex_subsys_top.u_ex_stage_ctrl.u_ctrl_assert.fail_count != 0) begin
      plain_error("a handshake assertion in the stage control failed");
    end else if (cycle_cnt > TIMEOUT_CYCLES) begin
      plain_error("timeout, the DUT stopped answering");
    end
  end

  // galois lfsr, one step per bit
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    logic        lsb;
    v = '0;
    for (int k = 0; k < n; k++) begin
      v   = {v[62:0], lfsr[0]};
      lsb = lfsr[0];
      lfsr = lfsr >> 1;
      if (lsb) lfsr = lfsr ^ 16'hB400;
    end
    return v;
  endfunction

  function automatic ex_isa_pkg::dec_pkt_t make_pkt(input ex_isa_pkg::op_e op,
      input logic [63:0] a, input logic [63:0] b, input logic [63:0] off,
      input logic [4:0] rd, input logic wen);
    ex_isa_pkg::dec_pkt_t p;
    p.opcode = op;
    p.pc     = pc_next;
    p.inst   = {pc_next[23:0], 8'(op)};
    p.op1    = a;
    p.op2    = b;
    p.op3    = off;
    p.rd     = rd;
    p.rd_wen = wen;
    pc_next  = pc_next + 64'd4;
    return p;
  endfunction

  // integer results as the ISA defines them
  function automatic logic [63:0] alu_expect(input ex_isa_pkg::op_e op,
      input logic [63:0] a, input logic [63:0] b);
    logic signed [63:0] sa;
    sa = a;
    case (op)
      ex_isa_pkg::ADD:  return a + b;
      ex_isa_pkg::SUB:  return a - b;
      ex_isa_pkg::AND:  return a & b;
      ex_isa_pkg::OR:   return a | b;
      ex_isa_pkg::XOR:  return a ^ b;
      ex_isa_pkg::SLL:  return a << b[5:0];
      ex_isa_pkg::SRL:  return a >> b[5:0];
      ex_isa_pkg::SRA:  return sa >>> b[5:0];
      ex_isa_pkg::SLT:  return {63'd0, sa < $signed(b)};
      ex_isa_pkg::SLTU: return {63'd0, a < b};
      ex_isa_pkg::LUI:  return a;
      default:          return '0;
    endcase
  endfunction

  // called on a falling edge, returns on a falling edge
  task automatic issue(input ex_isa_pkg::dec_pkt_t p, input int exp_lat,
                       input int ack_delay, output ex_isa_pkg::ret_pkt_t r);
    int lat;
    while (!o_dec_ack) @(negedge clk);
    i_dec_req = 1'b1;
    i_dec_pkt = p;
    @(negedge clk);
    i_dec_req = 1'b0;
    i_dec_pkt = '0;
    lat = 1;
    while (!o_ret_req) begin
      @(negedge clk);
      lat++;
    end
    assert (lat == exp_lat) else value_error("retire latency", lat, exp_lat);
    r = o_ret_pkt;
    for (int k = 0; k < ack_delay; k++) begin
      @(negedge clk);
      assert (o_ret_req && o_ret_pkt == r)
        else plain_error("retire packet changed while ack was held back");
    end
    i_ret_ack = 1'b1;
    @(negedge clk);
    i_ret_ack = 1'b0;
    assert (o_dec_ack && !o_ret_req && o_ret_pkt == '0)
      else plain_error("stage did not go back to idle after the retire ack");
    issued++;
  endtask

  task automatic check_ret(input ex_isa_pkg::ret_pkt_t r, input ex_isa_pkg::dec_pkt_t p,
      input logic exp_wen, input logic [63:0] exp_wdata, input logic exp_jmp,
      input logic [63:0] exp_addr, input logic [31:0] exp_intr);
    assert (r.pc == p.pc) else value_error("pc", r.pc, p.pc);
    assert (r.inst == p.inst) else value_error("inst", r.inst, p.inst);
    assert (r.rd == p.rd) else value_error("rd", r.rd, p.rd);
    assert (r.rd_wen == exp_wen) else value_error("rd_wen", r.rd_wen, exp_wen);
    if (exp_wen) begin
      assert (r.rd_wdata == exp_wdata) else value_error("rd_wdata", r.rd_wdata, exp_wdata);
    end
    assert (r.jmp == exp_jmp) else value_error("jmp", r.jmp, exp_jmp);
    if (exp_jmp) begin
      assert (r.jmpaddr == exp_addr) else value_error("jmpaddr", r.jmpaddr, exp_addr);
    end
    assert (r.intr_no == exp_intr) else value_error("intr_no", r.intr_no, exp_intr);
  endtask

  // rd gets the value the CSR had before the access
  task automatic csr_op(input ex_isa_pkg::op_e op, input logic [11:0] addr,
                        input logic [63:0] src, input logic [63:0] exp_old);
    ex_isa_pkg::dec_pkt_t p;
    ex_isa_pkg::ret_pkt_t r;
    p = make_pkt(op, src, {52'd0, addr}, '0, 5'd10, 1'b1);
    issue(p, 1, 1, r);
    check_ret(r, p, 1'b1, exp_old, 1'b0, '0, 32'd0);
  endtask

  task automatic run_branch(input ex_isa_pkg::op_e op, input logic [63:0] a,
                            input logic [63:0] b, input logic taken);
    ex_isa_pkg::dec_pkt_t p;
    ex_isa_pkg::ret_pkt_t r;
    p = make_pkt(op, a, b, 64'hFFFF_FFFF_FFFF_FFF0, 5'd0, 1'b0);
    issue(p, 1, 1, r);
    check_ret(r, p, 1'b0, '0, taken, p.pc + 64'hFFFF_FFFF_FFFF_FFF0, 32'd0);
  endtask

  task automatic test_alu();
    ex_isa_pkg::dec_pkt_t p;
    ex_isa_pkg::ret_pkt_t r;
    ex_isa_pkg::op_e      op;
    logic [63:0]          a;
    logic [63:0]          b;
    for (int i = 0; i < 20; i++) begin
      op = ex_isa_pkg::op_e'(int'(ex_isa_pkg::ADD) + (i % 11));
      a  = rand_bits(64);
      b  = rand_bits(64);
      p  = make_pkt(op, a, b, '0, 5'(i % 31 + 1), 1'b1);
      issue(p, 1, i % 4, r);
      check_ret(r, p, 1'b1, alu_expect(op, a, b), 1'b0, '0, 32'd0);
    end
  endtask

  task automatic test_branch_jump();
    ex_isa_pkg::dec_pkt_t p;
    ex_isa_pkg::ret_pkt_t r;
    logic [63:0]          a;
    a = rand_bits(64);
    run_branch(ex_isa_pkg::BEQ, a, a, 1'b1);
    run_branch(ex_isa_pkg::BEQ, a, a ^ 64'd1, 1'b0);
    run_branch(ex_isa_pkg::BNE, a, a ^ 64'h10, 1'b1);
    run_branch(ex_isa_pkg::BNE, a, a, 1'b0);
    // signed compare, -5 against 3
    run_branch(ex_isa_pkg::BLT, -64'sd5, 64'd3, 1'b1);
    run_branch(ex_isa_pkg::BLT, 64'd3, -64'sd5, 1'b0);
    run_branch(ex_isa_pkg::BGE, 64'd3, -64'sd5, 1'b1);
    run_branch(ex_isa_pkg::BGE, -64'sd5, 64'd3, 1'b0);
    p = make_pkt(ex_isa_pkg::JAL, '0, '0, 64'h100, 5'd1, 1'b1);
    issue(p, 1, 0, r);
    check_ret(r, p, 1'b1, p.pc + 64'd4, 1'b1, p.pc + 64'h100, 32'd0);
    a = rand_bits(64) | 64'd1;
    p = make_pkt(ex_isa_pkg::JALR, a, '0, 64'h20, 5'd1, 1'b1);
    issue(p, 1, 2, r);
    check_ret(r, p, 1'b1, p.pc + 64'd4, 1'b1, (a + 64'h20) & ~64'd1, 32'd0);
  endtask

  task automatic test_csr_ops();
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] c;
    a = rand_bits(64);
    b = rand_bits(64);
    c = rand_bits(64);
    csr_op(ex_isa_pkg::CSRRW, ex_csr_pkg::MSCRATCH, a, 64'd0);
    csr_op(ex_isa_pkg::CSRRS, ex_csr_pkg::MSCRATCH, b, a);
    csr_op(ex_isa_pkg::CSRRC, ex_csr_pkg::MSCRATCH, c, a | b);
    csr_op(ex_isa_pkg::CSRRS, ex_csr_pkg::MSCRATCH, 64'd0, (a | b) & ~c);
  endtask

  task automatic test_ecall();
    ex_isa_pkg::dec_pkt_t p;
    ex_isa_pkg::ret_pkt_t r;
    // decoder asks for a write, the trap channel must drop it
    p = make_pkt(ex_isa_pkg::ECALL, '0, '0, '0, 5'd0, 1'b1);
    issue(p, 4, 2, r);
    check_ret(r, p, 1'b0, '0, 1'b1, MTVEC_RST, 32'd0);
    csr_op(ex_isa_pkg::CSRRS, ex_csr_pkg::MEPC, 64'd0, p.pc);
    csr_op(ex_isa_pkg::CSRRS, ex_csr_pkg::MCAUSE, 64'd0, 64'd11);
  endtask

  task automatic test_timer_irq();
    ex_isa_pkg::dec_pkt_t p;
    ex_isa_pkg::ret_pkt_t r;
    logic [63:0]          a;
    logic [63:0]          b;
    i_mtime_overflow = 1'b1;
    a = rand_bits(64);
    b = rand_bits(64);
    // enables still clear, so the add must run
    p = make_pkt(ex_isa_pkg::ADD, a, b, '0, 5'd5, 1'b1);
    issue(p, 1, 0, r);
    check_ret(r, p, 1'b1, a + b, 1'b0, '0, 32'd0);
    csr_op(ex_isa_pkg::CSRRS, ex_csr_pkg::MSTATUS, 64'h8, 64'd0);
    csr_op(ex_isa_pkg::CSRRS, ex_csr_pkg::MIE, 64'h80, 64'd0);
    p = make_pkt(ex_isa_pkg::ADD, a, b, '0, 5'd3, 1'b1);
    issue(p, 4, 1, r);
    check_ret(r, p, 1'b0, '0, 1'b1, MTVEC_RST, 32'd7);
    irq_pc = p.pc;
    i_mtime_overflow = 1'b0;
    csr_op(ex_isa_pkg::CSRRS, ex_csr_pkg::MCAUSE, 64'd0, 64'h8000_0000_0000_0007);
    csr_op(ex_isa_pkg::CSRRS, ex_csr_pkg::MEPC, 64'd0, irq_pc);
    // MPIE took MIE, MIE cleared
    csr_op(ex_isa_pkg::CSRRS, ex_csr_pkg::MSTATUS, 64'd0, 64'h80);
  endtask

  task automatic test_mret();
    ex_isa_pkg::dec_pkt_t p;
    ex_isa_pkg::ret_pkt_t r;
    p = make_pkt(ex_isa_pkg::MRET, '0, '0, '0, 5'd0, 1'b1);
    issue(p, 4, 0, r);
    check_ret(r, p, 1'b0, '0, 1'b1, irq_pc, 32'd0);
    csr_op(ex_isa_pkg::CSRRS, ex_csr_pkg::MSTATUS, 64'd0, 64'h88);
  endtask

  initial begin
    clk              = 1'b0;
    rst              = 1'b1;
    i_dec_req        = 1'b0;
    i_dec_pkt        = '0;
    i_ret_ack        = 1'b0;
    i_mtime_overflow = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    assert (o_dec_ack && !o_ret_req) else plain_error("stage not idle after reset");
    test_alu();
    test_branch_jump();
    test_csr_ops();
    test_ecall();
    test_timer_irq();
    test_mret();
    if (issued == NUM_PKTS &&
        u_ex_subsys_top.u_ex_stage_ctrl.u_ctrl_assert.fail_count == 0) begin
      $display("Regression passed");
      $finish;
    end else begin
      plain_error("run ended with a wrong packet count or a failed assertion");
    end
  end

endmodule

// File: sim.f
hw/ex_isa_pkg.sv
hw/ex_csr_pkg.sv
hw/ex_csr_file.sv
hw/ex_alu_unit.sv
hw/ex_trap_unit.sv
hw/ex_stage_ctrl.sv
hw/ex_subsys_top.sv
tb/ex_stage_ctrl_assert.sv
tb/ex_tb.sv

// File: Bender.yml
package:
  name: ex_stage

sources:
  - files:
      - hw/ex_isa_pkg.sv
      - hw/ex_csr_pkg.sv
      - hw/ex_csr_file.sv
      - hw/ex_alu_unit.sv
      - hw/ex_trap_unit.sv
      - hw/ex_stage_ctrl.sv
      - hw/ex_subsys_top.sv
  - target: test
    files:
      - tb/ex_stage_ctrl_assert.sv
      - tb/ex_tb.sv
